// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= soc_tb
RTL_TOP   ?= soc_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= NO ERRORS

.PHONY: sim lint clean

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_if.sv
verilog/spi_device_bridge.sv
verilog/bus_decoder.sv
verilog/data_memory.sv
verilog/gpio_device.sv
verilog/soc_top.sv
verification/soc_tb.sv

// File: verification/soc_tb.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_tb;

    localparam int FRAME_BITS   = `SOC_FRAME_BITS;
    localparam int IDX_W        = $clog2(`SOC_MEM_WORDS);
    localparam logic [7:0] OP_WR = 8'h01;
    localparam logic [7:0] OP_RD = 8'h02;
    localparam int N_MEM        = 200;
    localparam int N_GPIO       = 40;
    localparam int N_UNMAP      = 30;
    localparam int N_BAD        = 30;
    // each frame is 8 clocks per bit plus cs_n setup and 16 idle clocks
    localparam int FRAME_CYCLES = 8 * FRAME_BITS + 32;
    localparam int TOTAL_FRAMES = 3 + N_MEM + N_GPIO + 2 * N_UNMAP + 2 * N_BAD + 8;
    localparam int LIMIT_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 1000;

    logic                      clk;
    logic                      arst_n;
    logic                      sclk;
    logic                      cs_n;
    logic                      sdi;
    logic                      spi_sdo_o;
    logic [`SOC_DATA_BITS-1:0] gpio_o;

    logic [31:0]               lfsr_state;
    logic [31:0]               model_mem [`SOC_MEM_WORDS];
    logic [31:0]               model_gpio;
    logic [FRAME_BITS-1:0]     last_result;
    int                        errors;
    int                        errors_base;
    int                        tests_run;
    int                        tests_failed;

    soc_top soc_top_inst (
        .clk_i      (clk       ),
        .arst_n_i   (arst_n    ),
        .spi_sclk_i (sclk      ),
        .spi_cs_n_i (cs_n      ),
        .spi_sdi_i  (sdi       ),
        .spi_sdo_o  (spi_sdo_o ),
        .gpio_o     (gpio_o    )
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // expected effect of one full frame and the result it leaves behind
    task automatic apply_model(input logic [7:0] op, input logic [7:0] addr,
                               input logic [31:0] data);
        logic [7:0]  status;
        logic [31:0] rdata;
        logic        is_mem;
        logic        is_gpio;
        is_mem  = addr < `SOC_MEM_WORDS;
        is_gpio = addr >= `SOC_GPIO_BASE && addr <= 8'h42;
        status  = 8'h00;
        rdata   = 32'h0;
        if (op == OP_WR) begin
            status = 8'h02;
            if (is_mem) begin
                model_mem[addr[IDX_W-1:0]] = data;
            end else if (is_gpio) begin
                case (addr)
                    8'h40:   model_gpio = data;
                    8'h41:   model_gpio = model_gpio | data;
                    default: model_gpio = model_gpio & ~data;
                endcase
            end else begin
                status = 8'h03;
            end
        end else if (op == OP_RD) begin
            if (is_mem) begin
                rdata = model_mem[addr[IDX_W-1:0]];
            end else if (is_gpio) begin
                rdata = model_gpio;
            end else begin
                status = 8'h01;
            end
        end else begin
            status = 8'h04;
        end
        last_result = {status, addr, rdata};
    endtask

    // mode 0 with sclk at clk/8 and sdo captured just before each rising sclk
    task automatic send_frame(input logic [FRAME_BITS-1:0] frame, input int nbits,
                              output logic [FRAME_BITS-1:0] got);
        logic [FRAME_BITS-1:0] sh;
        sh  = frame;
        got = '0;
        @(posedge clk);
        cs_n <= 1'b0;
        sclk <= 1'b0;
        sdi  <= sh[FRAME_BITS-1];
        repeat (4) @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            got = {got[FRAME_BITS-2:0], spi_sdo_o};
            @(posedge clk);
            sclk <= 1'b1;
            repeat (4) @(posedge clk);
            sh = {sh[FRAME_BITS-2:0], 1'b0};
            sclk <= 1'b0;
            sdi  <= sh[FRAME_BITS-1];
        end
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        sdi  <= 1'b0;
        repeat (16) @(posedge clk);
    endtask

    task automatic do_frame(input logic [7:0] op, input logic [7:0] addr,
                            input logic [31:0] data, input int nbits);
        logic [FRAME_BITS-1:0] got;
        logic [FRAME_BITS-1:0] exp_sdo;
        send_frame({op, addr, data}, nbits, got);
        exp_sdo = last_result >> (FRAME_BITS - nbits);
        assert (got === exp_sdo) else begin
            $display("mismatch spi_sdo_o: got %h, expected %h (op %h addr %h bits %0d)",
                     got, exp_sdo, op, addr, nbits);
            errors++;
        end
        if (nbits == FRAME_BITS) begin
            apply_model(op, addr, data);
        end
        assert (gpio_o === model_gpio) else begin
            $display("mismatch gpio_o: got %h, expected %h", gpio_o, model_gpio);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_base) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_base);
        end
        errors_base = errors;
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the test sequence did not finish in %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [7:0]  op;
        logic [7:0]  addr;
        int          nbits;
        clk          = 1'b0;
        arst_n       = 1'b0;
        sclk         = 1'b0;
        cs_n         = 1'b1;
        sdi          = 1'b0;
        lfsr_state   = 32'd67482;
        model_gpio   = '0;
        last_result  = '0;
        errors       = 0;
        errors_base  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        assert (gpio_o === 32'h0) else begin
            $display("mismatch gpio_o after reset: got %h, expected %h", gpio_o, 32'h0);
            errors++;
        end
        do_frame(OP_RD, 8'h00, 32'h0, FRAME_BITS);
        finish_test("reset_state");

        for (int i = 0; i < N_MEM; i++) begin
            draw_bits(1, r);
            op = r[0] ? OP_WR : OP_RD;
            draw_bits(IDX_W, r);
            addr = 8'(r);
            draw_bits(32, d);
            do_frame(op, addr, d, FRAME_BITS);
        end
        finish_test("memory_random");

        for (int i = 0; i < N_GPIO; i++) begin
            draw_bits(2, r);
            draw_bits(32, d);
            if (r < 32'd3) begin
                do_frame(OP_WR, 8'(`SOC_GPIO_BASE + r), d, FRAME_BITS);
            end else begin
                draw_bits(2, r);
                do_frame(OP_RD, 8'(`SOC_GPIO_BASE + (r % 32'd3)), d, FRAME_BITS);
            end
        end
        finish_test("gpio_set_clear");

        // an unmapped access followed by a memory read to see nothing moved
        for (int i = 0; i < N_UNMAP; i++) begin
            draw_bits(1, r);
            op = r[0] ? OP_WR : OP_RD;
            draw_bits(8, r);
            addr = 8'(32'h43 + (r % 32'd189));
            draw_bits(32, d);
            do_frame(op, addr, d, FRAME_BITS);
            draw_bits(IDX_W, r);
            do_frame(OP_RD, 8'(r), 32'h0, FRAME_BITS);
        end
        finish_test("unmapped_addr");

        for (int i = 0; i < N_BAD; i++) begin
            draw_bits(8, r);
            op = 8'(r);
            if (op == OP_WR || op == OP_RD) begin
                op = op ^ 8'h80;
            end
            draw_bits(8, r);
            addr = 8'(r);
            draw_bits(32, d);
            do_frame(op, addr, d, FRAME_BITS);
            // a short gpio write would change gpio_o if it were accepted
            draw_bits(6, r);
            nbits = 1 + int'(r % 32'd47);
            draw_bits(32, d);
            do_frame(OP_WR, `SOC_GPIO_BASE, d, nbits);
        end
        do_frame(OP_RD, `SOC_GPIO_BASE, 32'h0, FRAME_BITS);
        // one more frame brings out the result of the gpio read
        do_frame(OP_RD, 8'h00, 32'h0, FRAME_BITS);
        finish_test("bad_op_short_frame");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_decoder (
    input  logic   clk_i,
    input  logic   arst_n_i,
    bus_if.device  host,
    bus_if.host    mem,
    bus_if.host    gpio
);

    logic sel_mem;
    logic sel_gpio;
    logic sel_none;
    logic err_q;

    assign sel_mem  = (host.req_addr < `SOC_MEM_WORDS);
    assign sel_gpio = (host.req_addr >= `SOC_GPIO_BASE) &&
                      (host.req_addr <  `SOC_GPIO_BASE + `SOC_GPIO_REGS);
    assign sel_none = !sel_mem && !sel_gpio;

    // only the selected target sees req_valid
    assign mem.req_valid  = host.req_valid && sel_mem;
    assign mem.req_we     = host.req_we;
    assign mem.req_addr   = host.req_addr;
    assign mem.req_wdata  = host.req_wdata;

    // gpio sees its register offset
    assign gpio.req_valid = host.req_valid && sel_gpio;
    assign gpio.req_we    = host.req_we;
    assign gpio.req_addr  = host.req_addr - `SOC_GPIO_BASE;
    assign gpio.req_wdata = host.req_wdata;

    assign host.req_ready = sel_mem  ? mem.req_ready  :
                            sel_gpio ? gpio.req_ready : 1'b1;

    // unmapped addresses get an error a cycle later
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= host.req_valid && sel_none;
        end
    end

    assign host.rsp_valid = mem.rsp_valid || gpio.rsp_valid || err_q;
    assign host.rsp_rdata = mem.rsp_valid  ? mem.rsp_rdata  :
                            gpio.rsp_valid ? gpio.rsp_rdata : '0;
    assign host.rsp_err   = err_q || (mem.rsp_valid && mem.rsp_err) ||
                            (gpio.rsp_valid && gpio.rsp_err);

    a_rsp_after_xfer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        host.rsp_valid |-> $past(host.req_valid && host.req_ready));

    a_one_responder: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem.rsp_valid && gpio.rsp_valid));

endmodule

// File: verilog/bus_if.sv
`timescale 1ns/1ps
`include "soc_config.svh"

interface bus_if;

    logic                      req_valid;
    logic                      req_ready;
    logic                      req_we;
    logic [`SOC_ADDR_BITS-1:0] req_addr;
    logic [`SOC_DATA_BITS-1:0] req_wdata;

    // response comes one cycle after the transfer
    logic                      rsp_valid;
    logic [`SOC_DATA_BITS-1:0] rsp_rdata;
    logic                      rsp_err;

    modport host (
        output req_valid, req_we, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata, rsp_err
    );

    modport device (
        input  req_valid, req_we, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata, rsp_err
    );

endinterface

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module data_memory (
    input  logic   clk_i,
    input  logic   arst_n_i,
    bus_if.device  bus
);

    localparam int IDX_W = $clog2(`SOC_MEM_WORDS);

    logic [`SOC_DATA_BITS-1:0] mem_q [`SOC_MEM_WORDS];
    logic [`SOC_DATA_BITS-1:0] rdata_q;
    logic                      rsp_valid_q;
    logic                      xfer;
    logic [IDX_W-1:0]          idx;

    assign bus.req_ready = 1'b1;
    assign xfer          = bus.req_valid && bus.req_ready;
    assign idx           = bus.req_addr[IDX_W-1:0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (xfer && bus.req_we) begin
            mem_q[idx] <= bus.req_wdata;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= xfer;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            rdata_q <= bus.req_we ? '0 : mem_q[idx];
        end
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rdata_q;
    assign bus.rsp_err   = 1'b0;

    // the decoder must never route the gpio or unmapped range here
    a_addr_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        bus.req_valid && bus.req_ready |-> bus.req_addr < `SOC_MEM_WORDS);

endmodule

// File: verilog/gpio_device.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module gpio_device (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    bus_if.device                     bus,
    output logic [`SOC_DATA_BITS-1:0] gpio_o
);

    localparam logic [`SOC_ADDR_BITS-1:0] OFS_OUT = 'd0;
    localparam logic [`SOC_ADDR_BITS-1:0] OFS_SET = 'd1;
    localparam logic [`SOC_ADDR_BITS-1:0] OFS_CLR = 'd2;

    logic [`SOC_DATA_BITS-1:0] gpio_q;
    logic [`SOC_DATA_BITS-1:0] rdata_q;
    logic                      rsp_valid_q;
    logic                      xfer;

    assign bus.req_ready = 1'b1;
    assign xfer          = bus.req_valid && bus.req_ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= xfer;
            if (xfer && bus.req_we) begin
                case (bus.req_addr)
                    OFS_OUT: gpio_q <= bus.req_wdata;
                    OFS_SET: gpio_q <= gpio_q | bus.req_wdata;
                    OFS_CLR: gpio_q <= gpio_q & ~bus.req_wdata;
                    default: gpio_q <= gpio_q;
                endcase
            end
        end
    end

    // reads see the output register at every offset
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            rdata_q <= gpio_q;
        end
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rdata_q;
    assign bus.rsp_err   = 1'b0;
    assign gpio_o        = gpio_q;

endmodule

// File: verilog/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define SOC_ADDR_BITS 8
`define SOC_DATA_BITS 32

// one spi frame of opcode, address and data
`define SOC_FRAME_BITS 48

// address map
`define SOC_MEM_WORDS 64
`define SOC_GPIO_BASE 8'h40
`define SOC_GPIO_REGS 3

// spi pin synchronizer depth
`define SOC_SYNC_STAGES 2

`endif

// File: verilog/soc_pkg.sv
`include "soc_config.svh"

package soc_pkg;

    typedef enum logic [7:0] {
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02
    } opcode_e;

    typedef struct packed {
        logic [7:0]                opcode;
        logic [`SOC_ADDR_BITS-1:0] addr;
        logic [`SOC_DATA_BITS-1:0] data;
    } spi_wr_cmd_t;

    // read frames carry no payload in the tail
    typedef struct packed {
        logic [7:0]                opcode;
        logic [`SOC_ADDR_BITS-1:0] addr;
        logic [`SOC_DATA_BITS-1:0] unused;
    } spi_rd_cmd_t;

    typedef union packed {
        spi_wr_cmd_t wr;
        spi_rd_cmd_t rd;
    } spi_frame_u;

    typedef struct packed {
        logic [4:0] rsvd;
        logic       bad_op;
        logic       was_write;
        logic       bus_err;
    } status_t;

endpackage

// File: verilog/soc_top.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      spi_sclk_i,
    input  logic                      spi_cs_n_i,
    input  logic                      spi_sdi_i,
    output logic                      spi_sdo_o,
    output logic [`SOC_DATA_BITS-1:0] gpio_o
);

    bus_if host_bus ();
    bus_if mem_bus ();
    bus_if gpio_bus ();

    // single host on the bus
    spi_device_bridge u_spi_device_bridge (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .spi_sclk_i (spi_sclk_i ),
        .spi_cs_n_i (spi_cs_n_i ),
        .spi_sdi_i  (spi_sdi_i  ),
        .spi_sdo_o  (spi_sdo_o  ),
        .host       (host_bus   )
    );

    bus_decoder u_bus_decoder (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .host       (host_bus   ),
        .mem        (mem_bus    ),
        .gpio       (gpio_bus   )
    );

    data_memory u_data_memory (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .bus        (mem_bus    )
    );

    gpio_device u_gpio_device (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .bus        (gpio_bus   ),
        .gpio_o     (gpio_o     )
    );

endmodule

// File: verilog/spi_device_bridge.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module spi_device_bridge (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  spi_sclk_i,
    input  logic  spi_cs_n_i,
    input  logic  spi_sdi_i,
    output logic  spi_sdo_o,
    bus_if.host   host
);

    import soc_pkg::*;

    localparam int                 CNT_W    = $clog2(`SOC_FRAME_BITS + 2);
    localparam logic [CNT_W-1:0]   CNT_FULL = CNT_W'(`SOC_FRAME_BITS);
    localparam status_t            BAD_STATUS = '{rsvd: '0, bad_op: 1'b1,
                                                  was_write: 1'b0, bus_err: 1'b0};

    logic [`SOC_SYNC_STAGES-1:0]   sclk_sync_q;
    logic [`SOC_SYNC_STAGES-1:0]   cs_n_sync_q;
    logic [`SOC_SYNC_STAGES-1:0]   sdi_sync_q;
    logic                          sclk_s;
    logic                          cs_n_s;
    logic                          sdi_s;
    logic                          sclk_d_q;
    logic                          cs_n_d_q;
    logic                          sclk_rise;
    logic                          sclk_fall;
    logic                          cs_rise;
    logic                          cs_fall;

    logic [CNT_W-1:0]              bit_cnt_q;
    logic [`SOC_FRAME_BITS-1:0]    rx_q;
    logic [`SOC_FRAME_BITS-1:0]    tx_q;
    logic [`SOC_FRAME_BITS-1:0]    result_q;
    spi_frame_u                    frame;

    logic                          is_write;
    logic                          is_read;
    logic                          frame_ok;
    logic [`SOC_ADDR_BITS-1:0]     cmd_addr;
    status_t                       rsp_status;

    logic                          req_valid_q;
    logic                          busy_q;
    logic                          req_we_q;
    logic [`SOC_ADDR_BITS-1:0]     req_addr_q;
    logic [`SOC_DATA_BITS-1:0]     req_wdata_q;

    // cs_n idles high so its chain resets to ones
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sclk_sync_q <= '0;
            cs_n_sync_q <= '1;
            sdi_sync_q  <= '0;
            sclk_d_q    <= 1'b0;
            cs_n_d_q    <= 1'b1;
        end else begin
            sclk_sync_q <= {sclk_sync_q[`SOC_SYNC_STAGES-2:0], spi_sclk_i};
            cs_n_sync_q <= {cs_n_sync_q[`SOC_SYNC_STAGES-2:0], spi_cs_n_i};
            sdi_sync_q  <= {sdi_sync_q[`SOC_SYNC_STAGES-2:0], spi_sdi_i};
            sclk_d_q    <= sclk_s;
            cs_n_d_q    <= cs_n_s;
        end
    end

    assign sclk_s    = sclk_sync_q[`SOC_SYNC_STAGES-1];
    assign cs_n_s    = cs_n_sync_q[`SOC_SYNC_STAGES-1];
    assign sdi_s     = sdi_sync_q[`SOC_SYNC_STAGES-1];
    assign sclk_rise = sclk_s & ~sclk_d_q & ~cs_n_s;
    assign sclk_fall = ~sclk_s & sclk_d_q & ~cs_n_s;
    assign cs_rise   = cs_n_s & ~cs_n_d_q;
    assign cs_fall   = ~cs_n_s & cs_n_d_q;

    // counter saturates one past a full frame so long frames fail too
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt_q <= '0;
        end else if (cs_fall) begin
            bit_cnt_q <= '0;
        end else if (sclk_rise && bit_cnt_q <= CNT_FULL) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sclk_rise) begin
            rx_q <= {rx_q[`SOC_FRAME_BITS-2:0], sdi_s};
        end
    end

    // sdo shifts out the previous result msb first
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_q <= '0;
        end else if (cs_fall) begin
            tx_q <= result_q;
        end else if (sclk_fall) begin
            tx_q <= {tx_q[`SOC_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign spi_sdo_o = tx_q[`SOC_FRAME_BITS-1];

    assign frame    = rx_q;
    assign is_write = (frame.wr.opcode == OP_WRITE);
    assign is_read  = (frame.rd.opcode == OP_READ);
    assign cmd_addr = frame.rd.addr;
    assign frame_ok = cs_rise && (bit_cnt_q == CNT_FULL) && !busy_q;

    always_comb begin
        rsp_status           = '0;
        rsp_status.bus_err   = host.rsp_err;
        rsp_status.was_write = req_we_q;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_q <= 1'b0;
            busy_q      <= 1'b0;
            result_q    <= '0;
        end else begin
            if (frame_ok && (is_write || is_read)) begin
                req_valid_q <= 1'b1;
                busy_q      <= 1'b1;
            end else if (frame_ok) begin
                result_q <= {BAD_STATUS, cmd_addr, `SOC_DATA_BITS'(0)};
            end
            if (host.req_valid && host.req_ready) begin
                req_valid_q <= 1'b0;
            end
            if (host.rsp_valid) begin
                busy_q   <= 1'b0;
                // no read data after a write or an error
                result_q <= {rsp_status, req_addr_q,
                             (req_we_q || host.rsp_err) ? `SOC_DATA_BITS'(0) : host.rsp_rdata};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_ok && (is_write || is_read)) begin
            req_we_q    <= is_write;
            req_addr_q  <= cmd_addr;
            req_wdata_q <= is_write ? frame.wr.data : '0;
        end
    end

    assign host.req_valid = req_valid_q;
    assign host.req_we    = req_we_q;
    assign host.req_addr  = req_addr_q;
    assign host.req_wdata = req_wdata_q;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        host.req_valid && !host.req_ready |=>
            host.req_valid && $stable({host.req_we, host.req_addr, host.req_wdata}));

endmodule
